// File: verilog/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int xlen              = 32;
    localparam int arch_regs         = 32;
    localparam int rob_depth_default = 8;   // Tag width follows from this

    typedef logic [4:0] arch_reg_t;         // x0 reads zero and is never renamed
    typedef logic [$clog2(rob_depth_default)-1:0] rob_tag_t;

    typedef enum logic [2:0] {
        add    = 3'd0,
        sub    = 3'd1,
        and_op = 3'd2,
        or_op  = 3'd3,
        xor_op = 3'd4,
        mul    = 3'd5
    } alu_op_e;

    // Station class, derived from the opcode
    typedef enum logic {
        fu_alu = 1'b0,
        fu_mul = 1'b1
    } fu_class_e;

    typedef struct packed {
        logic            valid;
        alu_op_e         op;
        arch_reg_t       rs1;
        arch_reg_t       rs2;
        arch_reg_t       rd;
        logic            use_imm;   // Operand b comes from imm
        logic [xlen-1:0] imm;
    } dispatch_packet_t;

    // One source operand, either a value or the tag it waits for
    typedef struct packed {
        logic            ready;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } operand_t;

    typedef struct packed {
        logic            valid;
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } cdb_packet_t;

    typedef struct packed {
        logic            valid;
        alu_op_e         op;
        rob_tag_t        tag;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
    } issue_packet_t;

    typedef struct packed {
        logic            valid;
        arch_reg_t       rd;
        logic [xlen-1:0] value;
    } commit_packet_t;

endpackage

`default_nettype wire

// File: verilog/register_alias_table.sv
`timescale 1ns/1ps
`default_nettype none

module register_alias_table (
    input  logic                    clock,
    input  logic                    reset,
    input  ooo_pkg::arch_reg_t      rs1,
    input  ooo_pkg::arch_reg_t      rs2,
    input  ooo_pkg::arch_reg_t      rd,
    input  logic                    rename,
    input  ooo_pkg::rob_tag_t       new_tag,
    input  logic                    rob_ready1,
    input  logic                    rob_ready2,
    input  logic [31:0]             rob_value1,
    input  logic [31:0]             rob_value2,
    input  ooo_pkg::cdb_packet_t    cdb,
    input  ooo_pkg::commit_packet_t commit,
    input  ooo_pkg::rob_tag_t       commit_tag,
    output ooo_pkg::operand_t       src1,
    output ooo_pkg::operand_t       src2,
    output ooo_pkg::rob_tag_t       tag1,
    output ooo_pkg::rob_tag_t       tag2
);
    import ooo_pkg::*;

    logic [xlen-1:0]      regs [arch_regs];
    rob_tag_t             map_tag [arch_regs];
    logic [arch_regs-1:0] map_valid;   // Register has a pending producer

    // Regfile first, then a completed ROB entry, then the bus, else wait on the tag
    function automatic operand_t resolve(input logic mapped, input rob_tag_t tag,
                                         input logic [xlen-1:0] reg_value,
                                         input logic rob_done,
                                         input logic [xlen-1:0] rob_value,
                                         input cdb_packet_t bus);
        operand_t res;
        res = '{ready: 1'b1, tag: '0, value: reg_value};
        if (mapped) begin
            if (rob_done) begin
                res.value = rob_value;
            end else if (bus.valid && bus.tag == tag) begin
                res.value = bus.value;   // Broadcast in this very cycle
            end else begin
                res = '{ready: 1'b0, tag: tag, value: '0};
            end
        end
        return res;
    endfunction

    assign tag1 = map_tag[rs1];
    assign tag2 = map_tag[rs2];

    assign src1 = resolve(map_valid[rs1], map_tag[rs1], regs[rs1], rob_ready1, rob_value1, cdb);
    assign src2 = resolve(map_valid[rs2], map_tag[rs2], regs[rs2], rob_ready2, rob_value2, cdb);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            map_valid <= '0;
            for (int i = 0; i < arch_regs; i++) begin
                regs[i]    <= '0;
                map_tag[i] <= '0;
            end
        end else begin
            if (commit.valid && commit.rd != '0) begin   // x0 stays zero
                regs[commit.rd] <= commit.value;
                if (map_valid[commit.rd] && map_tag[commit.rd] == commit_tag) begin
                    map_valid[commit.rd] <= 1'b0;
                end
            end
            // A rename in the same cycle overrides the clear above
            if (rename && rd != '0) begin
                map_valid[rd] <= 1'b1;
                map_tag[rd]   <= new_tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int rob_depth = 8
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    allocate,
    input  ooo_pkg::arch_reg_t      alloc_rd,
    output ooo_pkg::rob_tag_t       tail_tag,
    output logic                    full,
    input  ooo_pkg::rob_tag_t       query1,
    input  ooo_pkg::rob_tag_t       query2,
    output logic                    done1,
    output logic                    done2,
    output logic [31:0]             value1,
    output logic [31:0]             value2,
    input  ooo_pkg::cdb_packet_t    cdb,
    output ooo_pkg::commit_packet_t commit,
    output ooo_pkg::rob_tag_t       commit_tag
);
    import ooo_pkg::*;

    rob_tag_t                   head;
    rob_tag_t                   tail;
    logic [$clog2(rob_depth):0] count;
    logic [rob_depth-1:0]       done;
    arch_reg_t                  rd_q [rob_depth];
    logic [xlen-1:0]            value_q [rob_depth];
    logic                       retire;

    assign tail_tag = tail;
    assign full     = (count == rob_depth);

    // Head leaves as soon as its result is in
    assign retire     = (count != '0) && done[head];
    assign commit     = '{valid: retire, rd: rd_q[head], value: value_q[head]};
    assign commit_tag = head;

    // Dispatch-time lookups for the rename path
    assign done1  = done[query1];
    assign done2  = done[query2];
    assign value1 = value_q[query1];
    assign value2 = value_q[query2];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (allocate) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;   // Wraps with the tag width
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({allocate, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (allocate) begin
            rd_q[tail] <= alloc_rd;
        end
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reservation_station.sv
`timescale 1ns/1ps
`default_nettype none

module reservation_station #(
    parameter int alu_entries = 3,
    parameter int mul_entries = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   allocate,
    input  ooo_pkg::alu_op_e       op,
    input  ooo_pkg::operand_t      src1,
    input  ooo_pkg::operand_t      src2,
    input  ooo_pkg::rob_tag_t      dest_tag,
    output logic                   space,
    input  ooo_pkg::cdb_packet_t   cdb,
    input  logic                   alu_ready,
    output ooo_pkg::issue_packet_t alu_issue,
    output ooo_pkg::issue_packet_t mul_issue
);
    import ooo_pkg::*;

    localparam int entries = alu_entries + mul_entries;
    localparam int idx_w   = $clog2(entries);

    logic [entries-1:0] busy;
    logic [idx_w-1:0]   age [entries];   // Entries allocated after this one
    alu_op_e            op_q [entries];
    rob_tag_t           dest_q [entries];
    operand_t           a_q [entries];
    operand_t           b_q [entries];

    fu_class_e          in_class;
    logic [idx_w-1:0]   alloc_idx;
    logic               alu_found;
    logic               mul_found;
    logic [idx_w-1:0]   alu_idx;
    logic [idx_w-1:0]   mul_idx;
    logic               alu_fire;

    // Low entries serve the ALU, the rest the multiplier
    function automatic fu_class_e entry_class(input int idx);
        return (idx < alu_entries) ? fu_alu : fu_mul;
    endfunction

    function automatic operand_t capture(input operand_t src, input cdb_packet_t bus);
        operand_t res;
        res = src;
        if (!src.ready && bus.valid && bus.tag == src.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    // Lowest free entry of the incoming class
    always_comb begin
        in_class  = (op == mul) ? fu_mul : fu_alu;
        space     = 1'b0;
        alloc_idx = '0;
        for (int i = entries - 1; i >= 0; i--) begin
            if (!busy[i] && entry_class(i) == in_class) begin
                space     = 1'b1;
                alloc_idx = idx_w'(i);
            end
        end
    end

    // Oldest ready entry per class
    always_comb begin
        alu_found = 1'b0;
        mul_found = 1'b0;
        alu_idx   = '0;
        mul_idx   = '0;
        for (int i = 0; i < entries; i++) begin
            if (busy[i] && a_q[i].ready && b_q[i].ready) begin
                if (entry_class(i) == fu_alu) begin
                    if (!alu_found || age[i] > age[alu_idx]) begin
                        alu_found = 1'b1;
                        alu_idx   = idx_w'(i);
                    end
                end else if (!mul_found || age[i] > age[mul_idx]) begin
                    mul_found = 1'b1;
                    mul_idx   = idx_w'(i);
                end
            end
        end
    end

    assign alu_fire = alu_found && alu_ready;   // Multiplier pipe never stalls

    assign alu_issue = '{valid: alu_fire, op: op_q[alu_idx], tag: dest_q[alu_idx],
                         a: a_q[alu_idx].value, b: b_q[alu_idx].value};
    assign mul_issue = '{valid: mul_found, op: op_q[mul_idx], tag: dest_q[mul_idx],
                         a: a_q[mul_idx].value, b: b_q[mul_idx].value};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= '0;
            for (int i = 0; i < entries; i++) begin
                age[i] <= '0;
            end
        end else begin
            if (allocate) begin
                for (int i = 0; i < entries; i++) begin
                    if (busy[i]) begin
                        age[i] <= age[i] + 1'b1;
                    end
                end
                busy[alloc_idx] <= 1'b1;
                age[alloc_idx]  <= '0;
            end
            // Issued entries free on the same edge
            if (alu_fire) begin
                busy[alu_idx] <= 1'b0;
            end
            if (mul_found) begin
                busy[mul_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < entries; i++) begin
            a_q[i] <= capture(a_q[i], cdb);   // Wakeup
            b_q[i] <= capture(b_q[i], cdb);
        end
        if (allocate) begin
            op_q[alloc_idx]   <= op;
            dest_q[alloc_idx] <= dest_tag;
            a_q[alloc_idx]    <= capture(src1, cdb);
            b_q[alloc_idx]    <= capture(src2, cdb);
        end
    end

endmodule

`default_nettype wire

// File: verilog/functional_units.sv
`timescale 1ns/1ps
`default_nettype none

module functional_units (
    input  logic                   clock,
    input  logic                   reset,
    input  ooo_pkg::issue_packet_t alu_issue,
    input  ooo_pkg::issue_packet_t mul_issue,
    output logic                   alu_ready,
    output ooo_pkg::cdb_packet_t   cdb
);
    import ooo_pkg::*;

    cdb_packet_t       alu_q;   // Held ALU result
    logic [xlen-1:0]   alu_value;
    logic              alu_sent;
    issue_packet_t     mul_s1;
    cdb_packet_t       mul_s2;
    cdb_packet_t       mul_s3;
    logic [2*xlen-1:0] product;

    always_comb begin
        case (alu_issue.op)
            add:     alu_value = alu_issue.a + alu_issue.b;
            sub:     alu_value = alu_issue.a - alu_issue.b;
            and_op:  alu_value = alu_issue.a & alu_issue.b;
            or_op:   alu_value = alu_issue.a | alu_issue.b;
            xor_op:  alu_value = alu_issue.a ^ alu_issue.b;
            default: alu_value = '0;   // mul goes to its own pipe
        endcase
    end

    assign product = mul_s1.a * mul_s1.b;

    // Multiplier owns the bus, ALU result waits behind it
    assign alu_sent  = alu_q.valid && !mul_s3.valid;
    assign alu_ready = !alu_q.valid || alu_sent;
    assign cdb       = mul_s3.valid ? mul_s3 : alu_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            alu_q  <= '0;
            mul_s1 <= '0;
            mul_s2 <= '0;
            mul_s3 <= '0;
        end else begin
            if (alu_issue.valid) begin
                alu_q <= '{valid: 1'b1, tag: alu_issue.tag, value: alu_value};
            end else if (alu_sent) begin
                alu_q.valid <= 1'b0;
            end
            mul_s1 <= mul_issue;
            mul_s2 <= '{valid: mul_s1.valid, tag: mul_s1.tag, value: product[xlen-1:0]};
            mul_s3 <= mul_s2;
        end
    end

endmodule

`default_nettype wire

// File: verilog/tomasulo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core #(
    parameter int alu_entries = 3,
    parameter int mul_entries = 2,
    parameter int rob_depth   = ooo_pkg::rob_depth_default
) (
    input  logic                      clock,
    input  logic                      reset,
    input  ooo_pkg::dispatch_packet_t dispatch,
    output logic                      dispatch_ready,
    output ooo_pkg::commit_packet_t   commit
);
    import ooo_pkg::*;

    logic            accept;
    logic            rob_full;
    logic            rs_space;
    logic            done1;
    logic            done2;
    logic            alu_ready;
    logic [xlen-1:0] value1;
    logic [xlen-1:0] value2;
    rob_tag_t        tail_tag;
    rob_tag_t        tag1;
    rob_tag_t        tag2;
    rob_tag_t        commit_tag;
    operand_t        src1;
    operand_t        src2;
    operand_t        src2_sel;
    cdb_packet_t     cdb;
    issue_packet_t   alu_issue;
    issue_packet_t   mul_issue;

    assign dispatch_ready = !rob_full && rs_space;
    assign accept         = dispatch.valid && dispatch_ready;

    // Immediate replaces the second source
    assign src2_sel = dispatch.use_imm ? operand_t'{ready: 1'b1, tag: '0, value: dispatch.imm}
                                       : src2;

    register_alias_table u_rat (
        .clock      (clock),
        .reset      (reset),
        .rs1        (dispatch.rs1),
        .rs2        (dispatch.rs2),
        .rd         (dispatch.rd),
        .rename     (accept),
        .new_tag    (tail_tag),
        .rob_ready1 (done1),
        .rob_ready2 (done2),
        .rob_value1 (value1),
        .rob_value2 (value2),
        .cdb        (cdb),
        .commit     (commit),
        .commit_tag (commit_tag),
        .src1       (src1),
        .src2       (src2),
        .tag1       (tag1),
        .tag2       (tag2)
    );

    reorder_buffer #(
        .rob_depth (rob_depth)
    ) u_rob (
        .clock      (clock),
        .reset      (reset),
        .allocate   (accept),
        .alloc_rd   (dispatch.rd),
        .tail_tag   (tail_tag),
        .full       (rob_full),
        .query1     (tag1),
        .query2     (tag2),
        .done1      (done1),
        .done2      (done2),
        .value1     (value1),
        .value2     (value2),
        .cdb        (cdb),
        .commit     (commit),
        .commit_tag (commit_tag)
    );

    reservation_station #(
        .alu_entries (alu_entries),
        .mul_entries (mul_entries)
    ) u_rs (
        .clock     (clock),
        .reset     (reset),
        .allocate  (accept),
        .op        (dispatch.op),
        .src1      (src1),
        .src2      (src2_sel),
        .dest_tag  (tail_tag),
        .space     (rs_space),
        .cdb       (cdb),
        .alu_ready (alu_ready),
        .alu_issue (alu_issue),
        .mul_issue (mul_issue)
    );

    functional_units u_fu (
        .clock     (clock),
        .reset     (reset),
        .alu_issue (alu_issue),
        .mul_issue (mul_issue),
        .alu_ready (alu_ready),
        .cdb       (cdb)
    );

endmodule

`default_nettype wire

// File: verif/tomasulo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tomasulo_core_tb;
    import ooo_pkg::*;

    // 5 + 6 + 5 + 5 + 4 directed instructions plus 200 random ones
    localparam int total_instr = 225;
    localparam int cycle_limit = 40 * total_instr + 100;

    logic             clock;
    logic             reset;
    dispatch_packet_t dispatch;
    logic             dispatch_ready;
    commit_packet_t   commit;

    logic [xlen-1:0]  model_regs [arch_regs];   // Sequential reference state
    commit_packet_t   expected_q [$];
    logic [31:0]      rng_state;
    int               mismatch_errors;
    int               other_errors;
    int               stall_cycles;
    int               cycles;

    tomasulo_core i_dut (
        .clock          (clock),
        .reset          (reset),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .commit         (commit)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] model_result(input alu_op_e op, input logic [31:0] a,
                                                 input logic [31:0] b);
        case (op)
            add:     return a + b;
            sub:     return a - b;
            and_op:  return a & b;
            or_op:   return a | b;
            xor_op:  return a ^ b;
            mul:     return a * b;   // Low half of the product
            default: return '0;
        endcase
    endfunction

    // Applies one instruction to the model and holds it on the port until accepted
    task automatic send_instr(input alu_op_e op, input arch_reg_t rd, input arch_reg_t rs1,
                              input arch_reg_t rs2, input logic use_imm,
                              input logic [31:0] imm);
        logic        accepted;
        logic [31:0] b;
        logic [31:0] result;
        b      = use_imm ? imm : model_regs[rs2];
        result = model_result(op, model_regs[rs1], b);
        expected_q.push_back('{valid: 1'b1, rd: rd, value: result});
        if (rd != '0) begin
            model_regs[rd] = result;
        end
        dispatch = '{valid: 1'b1, op: op, rs1: rs1, rs2: rs2, rd: rd,
                     use_imm: use_imm, imm: imm};
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clock);
            accepted = dispatch_ready;
            if (!accepted) begin
                stall_cycles++;
            end
            @(posedge clock);
            #1;
        end
        dispatch = '0;
    endtask

    task automatic drain_commits();
        while (expected_q.size() != 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic check_idle_after_reset();
        dispatch.op = add;
        @(negedge clock);
        assert (dispatch_ready) else begin
            other_errors++;
            $display("dispatch_ready was low for an ALU op right after reset");
        end
        assert (!commit.valid) else begin
            other_errors++;
            $display("commit.valid was high right after reset");
        end
        @(posedge clock);
        #1;
        dispatch.op = mul;
        @(negedge clock);
        assert (dispatch_ready) else begin
            other_errors++;
            $display("dispatch_ready was low for a mul right after reset");
        end
        @(posedge clock);
        #1;
        dispatch = '0;
    endtask

    task automatic independent_alu_ops();
        send_instr(add,    5'd1,  5'd0, 5'd0, 1'b1, 32'h0000_1234);
        drain_commits();   // x1 settles in the regfile before the others read it
        send_instr(sub,    5'd2,  5'd1, 5'd0, 1'b1, 32'h0000_0003);
        send_instr(or_op,  5'd3,  5'd1, 5'd0, 1'b1, 32'h0000_abcd);
        send_instr(xor_op, 5'd4,  5'd1, 5'd0, 1'b1, 32'h5a5a_5a5a);
        send_instr(and_op, 5'd13, 5'd1, 5'd0, 1'b1, 32'h0000_0ff0);
        drain_commits();
    endtask

    task automatic raw_chain();
        send_instr(add,    5'd5, 5'd0, 5'd0, 1'b1, 32'd7);
        send_instr(add,    5'd6, 5'd5, 5'd5, 1'b0, 32'd0);
        send_instr(sub,    5'd7, 5'd6, 5'd5, 1'b0, 32'd0);
        send_instr(xor_op, 5'd8, 5'd7, 5'd6, 1'b0, 32'd0);
        send_instr(or_op,  5'd9, 5'd8, 5'd0, 1'b1, 32'h0f00_0000);
        send_instr(and_op, 5'd5, 5'd9, 5'd6, 1'b0, 32'd0);
        drain_commits();
    endtask

    task automatic mul_then_alu();
        send_instr(mul,    5'd12, 5'd3, 5'd0, 1'b1, 32'h1234_5679);   // Wide product
        send_instr(add,    5'd16, 5'd1, 5'd2, 1'b0, 32'd0);
        send_instr(xor_op, 5'd17, 5'd4, 5'd0, 1'b1, 32'hffff_0000);
        send_instr(sub,    5'd18, 5'd1, 5'd4, 1'b0, 32'd0);
        send_instr(or_op,  5'd19, 5'd2, 5'd3, 1'b0, 32'd0);
        drain_commits();
    endtask

    task automatic alu_station_full();
        int stalls_before;
        stalls_before = stall_cycles;
        send_instr(mul,    5'd10, 5'd1,  5'd2,  1'b0, 32'd0);
        send_instr(add,    5'd11, 5'd10, 5'd0,  1'b1, 32'd1);
        send_instr(sub,    5'd20, 5'd10, 5'd1,  1'b0, 32'd0);
        send_instr(xor_op, 5'd21, 5'd10, 5'd4,  1'b0, 32'd0);
        send_instr(and_op, 5'd22, 5'd10, 5'd10, 1'b0, 32'd0);   // Finds no free entry
        drain_commits();
        assert (stall_cycles > stalls_before) else begin
            other_errors++;
            $display("dispatch_ready never dropped while the ALU station was full");
        end
    endtask

    task automatic x0_writes();
        send_instr(add,   5'd0,  5'd1, 5'd0, 1'b1, 32'd5);
        send_instr(add,   5'd14, 5'd0, 5'd1, 1'b0, 32'd0);
        send_instr(mul,   5'd0,  5'd1, 5'd2, 1'b0, 32'd0);
        send_instr(or_op, 5'd15, 5'd0, 5'd0, 1'b0, 32'd0);
        drain_commits();
    endtask

    task automatic random_program(input int count);
        logic [31:0] r1;
        logic [31:0] r2;
        for (int i = 0; i < count; i++) begin
            rng_state = xorshift32(rng_state);
            r1        = rng_state;
            rng_state = xorshift32(rng_state);
            r2        = rng_state;
            send_instr(alu_op_e'(3'(r1 % 6)), r1[22:18], r1[12:8], r1[17:13], r1[23], r2);
        end
        drain_commits();
    endtask

    // Every retirement is compared against the oldest outstanding model result
    always @(negedge clock) begin
        commit_packet_t exp;
        if (!reset && commit.valid) begin
            assert (expected_q.size() != 0) else begin
                other_errors++;
                $display("Commit of x%0d arrived with no instruction outstanding", commit.rd);
            end
            if (expected_q.size() != 0) begin
                exp = expected_q.pop_front();
                assert (commit.rd == exp.rd) else begin
                    mismatch_errors++;
                    $display("mismatch commit.rd: got 0x%h expected 0x%h", commit.rd, exp.rd);
                end
                assert (commit.value == exp.value) else begin
                    mismatch_errors++;
                    $display("mismatch commit.value: got 0x%h expected 0x%h",
                             commit.value, exp.value);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d commits outstanding",
                     cycles, expected_q.size());
            $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors + 1);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        reset           = 1'b1;
        dispatch        = '0;
        rng_state       = 32'h2cb5145c;
        mismatch_errors = 0;
        other_errors    = 0;
        stall_cycles    = 0;
        cycles          = 0;
        for (int i = 0; i < arch_regs; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;

        check_idle_after_reset();
        independent_alu_ops();
        raw_chain();
        mul_then_alu();
        alu_station_full();
        x0_writes();
        random_program(200);

        repeat (10) @(posedge clock);   // Catch any late extra commit
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tomasulo_core.f
verilog/ooo_pkg.sv
verilog/register_alias_table.sv
verilog/reorder_buffer.sv
verilog/reservation_station.sv
verilog/functional_units.sv
verilog/tomasulo_core.sv
verif/tomasulo_core_tb.sv

// File: Bender.yml
package:
  name: tomasulo_core

sources:
  - files:
      - verilog/ooo_pkg.sv
      - verilog/register_alias_table.sv
      - verilog/reorder_buffer.sv
      - verilog/reservation_station.sv
      - verilog/functional_units.sv
      - verilog/tomasulo_core.sv
  - target: test
    files:
      - verif/tomasulo_core_tb.sv
